//--- source/accCoreSettings.svh
`ifndef ACC_CORE_SETTINGS_SVH
`define ACC_CORE_SETTINGS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------

// accumulators, alu and instruction constant
`define DATA_W 8

// full instruction word
`define INSTR_W 16

// opcode field sits in the top bits of the word
`define OPCODE_W 6

// info field below the opcode, also the pc and target width
`define INFO_W 10

// relative branch offset, low bits of the info field
`define REL_W 6

`endif

//--- source/accCorePkg.sv
`include "accCoreSettings.svh"

package accCorePkg;

	// ------------------------------------------------------------
	// instruction encoding
	// ------------------------------------------------------------

	// codes not listed here decode as nop
	typedef enum logic [`OPCODE_W-1:0] {
		opNop = 6'h00,
		opLdca = 6'h01,
		opLdcb = 6'h02,
		opAdda = 6'h04,
		opAddb = 6'h05,
		opAddca = 6'h06,
		opAddcb = 6'h07,
		opSuba = 6'h08,
		opSubb = 6'h09,
		opSubca = 6'h0a,
		opSubcb = 6'h0b,
		opAnda = 6'h0c,
		opAndb = 6'h0d,
		opAndca = 6'h0e,
		opAndcb = 6'h0f,
		opOra = 6'h10,
		opOrb = 6'h11,
		opOrca = 6'h12,
		opOrcb = 6'h13,
		opAsla = 6'h14,
		opAsra = 6'h15,
		opJmp = 6'h20,
		opBaeq = 6'h21,
		opBane = 6'h22,
		opBami = 6'h23,
		opBapl = 6'h24,
		opBbeq = 6'h25,
		opBbne = 6'h26,
		opBbmi = 6'h27,
		opBbpl = 6'h28
	} opcode_t;

	// loads, constant forms and relative branches
	typedef struct packed {
		opcode_t opcode;
		logic [`INSTR_W-`OPCODE_W-`DATA_W-1:0] spare;
		logic [`DATA_W-1:0] constant;
	} constView_t;

	// jmp carries a full program address
	typedef struct packed {
		opcode_t opcode;
		logic [`INSTR_W-`OPCODE_W-1:0] address;
	} absView_t;

	// same 16-bit word, read per opcode
	typedef union packed {
		constView_t constView;
		absView_t absView;
	} instrWord_t;

	// ------------------------------------------------------------
	// control and pipeline types
	// ------------------------------------------------------------

	typedef enum logic [1:0] {none, writeA, writeB} accSel_t;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluShiftLeft, aluShiftRight, aluPassConst
	} aluOp_t;

	typedef enum logic [2:0] {condNever, condAlways, condEq, condNe, condMi, condPl} branchCond_t;

	// useRegA: first operand is an accumulator, else the constant
	// testB: that accumulator is B, also the one a branch tests
	// useRegB: second operand is B, else the constant
	typedef struct packed {
		aluOp_t aluOp;
		accSel_t dest;
		logic useRegA;
		logic useRegB;
		logic testB;
		branchCond_t branchCond;
		logic [`DATA_W-1:0] constant;
		logic [`INFO_W-1:0] branchTarget;
	} decodedInstr_t;

	// low valid marks a bubble
	typedef struct packed {
		logic valid;
		decodedInstr_t ctrl;
		logic [`DATA_W-1:0] accA;
		logic [`DATA_W-1:0] accB;
	} idExReg_t;

	// dest none means nothing is written
	typedef struct packed {
		accSel_t dest;
		logic [`DATA_W-1:0] data;
	} writeback_t;

endpackage

//--- source/alu.sv
`timescale 1ns/1ps
`include "accCoreSettings.svh"

module alu
	import accCorePkg::*;
(
	input logic [`DATA_W-1:0] operandA,
	input logic [`DATA_W-1:0] operandB,
	input logic [`DATA_W-1:0] constant,
	input aluOp_t aluOp,
	output logic [`DATA_W-1:0] result,
	output logic zero,
	output logic negative
);

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------

	always_comb begin
		case (aluOp)
			aluAdd: result = operandA + operandB;
			// first minus second, carry out dropped
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			// zero in at the lsb
			aluShiftLeft: result = {operandA[`DATA_W-2:0], 1'b0};
			// msb filled with zero
			aluShiftRight: result = {1'b0, operandA[`DATA_W-1:1]};
			aluPassConst: result = constant;
			default: result = constant;
		endcase
	end

	// ------------------------------------------------------------
	// condition flags
	// ------------------------------------------------------------

	// flags look at the first operand
	// for a branch that is the tested accumulator
	assign zero = (operandA == '0);
	assign negative = operandA[`DATA_W-1];

endmodule

//--- source/instrDecoder.sv
`timescale 1ns/1ps
`include "accCoreSettings.svh"

module instrDecoder
	import accCorePkg::*;
(
	input instrWord_t instr,
	input logic [`INFO_W-1:0] pc,
	output decodedInstr_t decoded
);

	opcode_t opcode;
	logic [`REL_W-1:0] relOffset;
	logic [`INFO_W-1:0] relTarget;

	// opcode sits in the same bits in both views
	assign opcode = instr.constView.opcode;

	// relative offset is unsigned, wraps at the top of program space
	assign relOffset = instr.constView.constant[`REL_W-1:0];
	assign relTarget = pc + {{(`INFO_W-`REL_W){1'b0}}, relOffset};

	always_comb begin
		// defaults describe a nop
		decoded.aluOp = aluPassConst;
		decoded.dest = none;
		decoded.useRegA = 1'b0;
		decoded.useRegB = 1'b0;
		decoded.testB = 1'b0;
		decoded.branchCond = condNever;
		decoded.constant = instr.constView.constant;
		decoded.branchTarget = relTarget;

		// ------------------------------------------------------------
		// alu operation per opcode family
		// ------------------------------------------------------------
		case (opcode)
			opAdda, opAddb, opAddca, opAddcb: decoded.aluOp = aluAdd;
			opSuba, opSubb, opSubca, opSubcb: decoded.aluOp = aluSub;
			opAnda, opAndb, opAndca, opAndcb: decoded.aluOp = aluAnd;
			opOra, opOrb, opOrca, opOrcb: decoded.aluOp = aluOr;
			opAsla: decoded.aluOp = aluShiftLeft;
			opAsra: decoded.aluOp = aluShiftRight;
			default: decoded.aluOp = aluPassConst;
		endcase

		// ------------------------------------------------------------
		// destination, operand routing and branch condition
		// ------------------------------------------------------------
		case (opcode)
			opLdca: begin
				decoded.dest = writeA;
			end
			opLdcb: begin
				decoded.dest = writeB;
			end
			// A <- A op B
			opAdda, opSuba, opAnda, opOra: begin
				decoded.dest = writeA;
				decoded.useRegA = 1'b1;
				decoded.useRegB = 1'b1;
			end
			// B <- A op B
			opAddb, opSubb, opAndb, opOrb: begin
				decoded.dest = writeB;
				decoded.useRegA = 1'b1;
				decoded.useRegB = 1'b1;
			end
			// A <- A op const, shifts only look at A
			opAddca, opSubca, opAndca, opOrca, opAsla, opAsra: begin
				decoded.dest = writeA;
				decoded.useRegA = 1'b1;
			end
			// B <- B op const, B moves to the first operand
			opAddcb, opSubcb, opAndcb, opOrcb: begin
				decoded.dest = writeB;
				decoded.useRegA = 1'b1;
				decoded.testB = 1'b1;
			end
			// absolute target from the other view
			opJmp: begin
				decoded.branchCond = condAlways;
				decoded.branchTarget = instr.absView.address;
			end
			// conditional branches test A or B
			opBaeq, opBbeq: begin
				decoded.useRegA = 1'b1;
				decoded.testB = (opcode == opBbeq);
				decoded.branchCond = condEq;
			end
			opBane, opBbne: begin
				decoded.useRegA = 1'b1;
				decoded.testB = (opcode == opBbne);
				decoded.branchCond = condNe;
			end
			opBami, opBbmi: begin
				decoded.useRegA = 1'b1;
				decoded.testB = (opcode == opBbmi);
				decoded.branchCond = condMi;
			end
			opBapl, opBbpl: begin
				decoded.useRegA = 1'b1;
				decoded.testB = (opcode == opBbpl);
				decoded.branchCond = condPl;
			end
			default: begin
				decoded.dest = none;
			end
		endcase
	end

endmodule

//--- source/decodeStage.sv
`timescale 1ns/1ps
`include "accCoreSettings.svh"

module decodeStage
	import accCorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input instrWord_t instr,
	input logic [`INFO_W-1:0] pc,
	input writeback_t wb,
	output idExReg_t idEx,
	output logic [`DATA_W-1:0] accA,
	output logic [`DATA_W-1:0] accB
);

	decodedInstr_t decoded;

	// ------------------------------------------------------------
	// field decode
	// ------------------------------------------------------------

	instrDecoder decoder_i (
		.instr(instr),
		.pc(pc),
		.decoded(decoded)
	);

	// ------------------------------------------------------------
	// accumulator pair
	// ------------------------------------------------------------

	// one accumulator written per cycle at most
	always_ff @(posedge clk) begin
		if (reset) begin
			accA <= '0;
			accB <= '0;
		end else if (wb.dest == writeA) begin
			accA <= wb.data;
		end else if (wb.dest == writeB) begin
			accB <= wb.data;
		end
	end

	// ------------------------------------------------------------
	// ID/EX register
	// ------------------------------------------------------------

	// accumulators read here may miss the write landing this edge
	// execute patches that through its forwarding register
	always_ff @(posedge clk) begin
		idEx.valid <= instrValid;
		idEx.ctrl <= decoded;
		idEx.accA <= accA;
		idEx.accB <= accB;
		// only the strobe matters after reset
		if (reset) begin
			idEx.valid <= 1'b0;
		end
	end

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps
`include "accCoreSettings.svh"

module executeStage
	import accCorePkg::*;
(
	input logic clk,
	input logic reset,
	input idExReg_t idEx,
	output writeback_t wb,
	output logic branchTaken,
	output logic [`INFO_W-1:0] branchTarget
);

	writeback_t fwdReg;
	logic [`DATA_W-1:0] curA;
	logic [`DATA_W-1:0] curB;
	logic [`DATA_W-1:0] operandA;
	logic [`DATA_W-1:0] operandB;
	logic [`DATA_W-1:0] aluResult;
	logic aluZero;
	logic aluNegative;
	logic condMet;
	logic takeBranch;

	// ------------------------------------------------------------
	// forwarding
	// ------------------------------------------------------------

	// previous instruction wrote at the edge that captured idEx
	// so its result replaces the stale accumulator copy
	assign curA = (fwdReg.dest == writeA) ? fwdReg.data : idEx.accA;
	assign curB = (fwdReg.dest == writeB) ? fwdReg.data : idEx.accB;

	// forwarding first, then the constant select
	assign operandA = idEx.ctrl.useRegA ? (idEx.ctrl.testB ? curB : curA) : idEx.ctrl.constant;
	assign operandB = idEx.ctrl.useRegB ? curB : idEx.ctrl.constant;

	alu alu_i (
		.operandA(operandA),
		.operandB(operandB),
		.constant(idEx.ctrl.constant),
		.aluOp(idEx.ctrl.aluOp),
		.result(aluResult),
		.zero(aluZero),
		.negative(aluNegative)
	);

	// ------------------------------------------------------------
	// writeback and branch
	// ------------------------------------------------------------

	// accumulators load this at the next edge
	assign wb.dest = idEx.valid ? idEx.ctrl.dest : none;
	assign wb.data = aluResult;

	always_comb begin
		case (idEx.ctrl.branchCond)
			condAlways: condMet = 1'b1;
			condEq: condMet = aluZero;
			condNe: condMet = !aluZero;
			condMi: condMet = aluNegative;
			condPl: condMet = !aluNegative;
			default: condMet = 1'b0;
		endcase
	end

	// bubbles never branch
	assign takeBranch = idEx.valid && condMet;

	// last writeback, dest none after a bubble or branch
	always_ff @(posedge clk) begin
		fwdReg <= wb;
		if (reset) begin
			fwdReg.dest <= none;
		end
	end

	// pulse for one cycle, target held until the next taken branch
	always_ff @(posedge clk) begin
		if (reset) begin
			branchTaken <= 1'b0;
			branchTarget <= '0;
		end else begin
			branchTaken <= takeBranch;
			if (takeBranch) begin
				branchTarget <= idEx.ctrl.branchTarget;
			end
		end
	end

endmodule

//--- source/accCore.sv
`timescale 1ns/1ps
`include "accCoreSettings.svh"

module accCore
	import accCorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input instrWord_t instr,
	input logic [`INFO_W-1:0] pc,
	output logic [`DATA_W-1:0] accA,
	output logic [`DATA_W-1:0] accB,
	output logic branchTaken,
	output logic [`INFO_W-1:0] branchTarget
);

	// decode to execute
	idExReg_t idEx;

	// execute back to the accumulators
	writeback_t wb;

	decodeStage decode_i (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.wb(wb),
		.idEx(idEx),
		.accA(accA),
		.accB(accB)
	);

	executeStage execute_i (
		.clk(clk),
		.reset(reset),
		.idEx(idEx),
		.wb(wb),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

endmodule

//--- tests/accCoreTb.sv
`timescale 1ns/1ps
`include "accCoreSettings.svh"

module accCoreTb
	import accCorePkg::*;
();

	localparam real CLK_PERIOD = 4.0;
	localparam real RUN_LIMIT = 20000.0;

	// outputs expected once an instruction has retired
	typedef struct packed {
		logic [`DATA_W-1:0] accA;
		logic [`DATA_W-1:0] accB;
		logic taken;
		logic [`INFO_W-1:0] target;
	} expectState_t;

	logic clk = 1'b0;
	logic reset;
	logic instrValid;
	instrWord_t instr;
	logic [`INFO_W-1:0] pc;
	logic [`DATA_W-1:0] accA;
	logic [`DATA_W-1:0] accB;
	logic branchTaken;
	logic [`INFO_W-1:0] branchTarget;

	// sequential reference model
	logic [`DATA_W-1:0] modelA;
	logic [`DATA_W-1:0] modelB;
	logic modelTaken;
	logic [`INFO_W-1:0] modelTarget;
	expectState_t pending[$];
	int checkCount;
	int errorCount;
	integer seed;
	event abortRun;

	accCore dut_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	// each of the n edges gets its own time limit of two periods
	task automatic waitEdges(input int n, input bit rising);
		bit seen;
		for (int i = 0; i < n; i++) begin
			seen = 1'b0;
			fork
				begin
					if (rising)
						@(posedge clk);
					else
						@(negedge clk);
					seen = 1'b1;
				end
				#(2 * CLK_PERIOD);
			join_any
			if (!seen) begin
				$display("timeout: clock edge did not arrive in time");
				-> abortRun;
			end
		end
	endtask

	task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
			input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERR %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
		end
	endtask

	// applies one instruction in program order
	task automatic applyModel(input opcode_t op, input logic [`INFO_W-1:0] info,
			input logic [`INFO_W-1:0] pcVal);
		logic [`DATA_W-1:0] k;
		logic [`INFO_W-1:0] relTarget;
		k = info[`DATA_W-1:0];
		// zero-extended offset wraps at 1024
		relTarget = pcVal + {{(`INFO_W-`REL_W){1'b0}}, info[`REL_W-1:0]};
		case (op)
			opLdca: modelA = k;
			opLdcb: modelB = k;
			opAdda: modelA = modelA + modelB;
			opAddb: modelB = modelA + modelB;
			opAddca: modelA = modelA + k;
			opAddcb: modelB = modelB + k;
			opSuba: modelA = modelA - modelB;
			opSubb: modelB = modelA - modelB;
			opSubca: modelA = modelA - k;
			opSubcb: modelB = modelB - k;
			opAnda: modelA = modelA & modelB;
			opAndb: modelB = modelA & modelB;
			opAndca: modelA = modelA & k;
			opAndcb: modelB = modelB & k;
			opOra: modelA = modelA | modelB;
			opOrb: modelB = modelA | modelB;
			opOrca: modelA = modelA | k;
			opOrcb: modelB = modelB | k;
			opAsla: modelA = modelA << 1;
			opAsra: modelA = modelA >> 1;
			opJmp: modelTaken = 1'b1;
			opBaeq: modelTaken = (modelA == '0);
			opBane: modelTaken = (modelA != '0);
			opBami: modelTaken = modelA[`DATA_W-1];
			opBapl: modelTaken = !modelA[`DATA_W-1];
			opBbeq: modelTaken = (modelB == '0);
			opBbne: modelTaken = (modelB != '0);
			opBbmi: modelTaken = modelB[`DATA_W-1];
			opBbpl: modelTaken = !modelB[`DATA_W-1];
			default: ;
		endcase
		if (modelTaken)
			modelTarget = (op == opJmp) ? info : relTarget;
	endtask

	task automatic expectAcc(input expectState_t e);
		checkValue(16'(accA), 16'(e.accA), "accA");
		checkValue(16'(accB), 16'(e.accB), "accB");
	endtask

	task automatic expectBranch(input expectState_t e);
		checkValue(16'(branchTaken), 16'(e.taken), "branchTaken");
		checkValue(16'(branchTarget), 16'(e.target), "branchTarget");
	endtask

	// drive at the rising edge and check at the falling edge
	// the entry two slots back is the one now visible
	task automatic stepCycle(input logic valid, input opcode_t op,
			input logic [`INFO_W-1:0] info, input logic [`INFO_W-1:0] pcVal);
		expectState_t e;
		waitEdges(1, 1'b1);
		instrValid <= valid;
		instr <= {op, info};
		pc <= pcVal;
		modelTaken = 1'b0;
		if (valid)
			applyModel(op, info, pcVal);
		e.accA = modelA;
		e.accB = modelB;
		e.taken = modelTaken;
		e.target = modelTarget;
		pending.push_back(e);
		waitEdges(1, 1'b0);
		if (pending.size() > 2) begin
			e = pending.pop_front();
			expectAcc(e);
			expectBranch(e);
		end
	endtask

	task automatic sendInstr(input opcode_t op, input logic [`INFO_W-1:0] info,
			input logic [`INFO_W-1:0] pcVal);
		stepCycle(1'b1, op, info, pcVal);
	endtask

	task automatic sendBubble();
		stepCycle(1'b0, opNop, '0, '0);
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------

	task automatic resetLoadTest();
		checkValue(16'(accA), 16'h0, "accA after reset");
		checkValue(16'(accB), 16'h0, "accB after reset");
		checkValue(16'(branchTaken), 16'h0, "branchTaken after reset");
		checkValue(16'(branchTarget), 16'h0, "branchTarget after reset");
		sendInstr(opLdca, 10'h05a, '0);
		sendBubble();
		sendInstr(opLdcb, 10'h0c3, '0);
		sendBubble();
		sendBubble();
	endtask

	// every code from ADDA up to ASRA with bubbles in between
	task automatic aluFormsTest();
		opcode_t op;
		for (int code = 'h04; code <= 'h15; code++) begin
			op = opcode_t'(code[`OPCODE_W-1:0]);
			sendInstr(opLdca, 10'(code * 37 + 5), '0);
			sendBubble();
			sendInstr(opLdcb, 10'(code * 91 + 200), '0);
			sendBubble();
			sendInstr(op, 10'(code * 53 + 17), '0);
			sendBubble();
		end
	endtask

	// back to back so each reads what the one before wrote
	task automatic forwardingTest();
		sendInstr(opLdca, 10'h011, '0);
		sendInstr(opLdcb, 10'h022, '0);
		sendInstr(opAdda, '0, '0);
		sendInstr(opAdda, '0, '0);
		sendInstr(opAdda, '0, '0);
		sendInstr(opSubb, '0, '0);
		sendInstr(opOrb, '0, '0);
		sendInstr(opAndcb, 10'h0f0, '0);
		sendInstr(opAddb, '0, '0);
		sendInstr(opAsla, '0, '0);
		sendInstr(opSuba, '0, '0);
		sendInstr(opAsra, '0, '0);
		sendInstr(opLdcb, 10'h07f, '0);
		sendInstr(opAddcb, 10'h001, '0);
		sendBubble();
		sendBubble();
	endtask

	task automatic branchTest();
		logic [`DATA_W-1:0] values [3];
		opcode_t op;
		values = '{8'h00, 8'h35, 8'h80};
		for (int v = 0; v < 3; v++) begin
			for (int code = 'h21; code <= 'h28; code++) begin
				op = opcode_t'(code[`OPCODE_W-1:0]);
				// tested accumulator written just before
				sendInstr((code < 'h25) ? opLdca : opLdcb, {2'b00, values[v]}, '0);
				sendInstr(op, 10'(code * 7 + v), 10'(code * 16 + v));
				sendBubble();
			end
		end
		sendInstr(opJmp, 10'h2a5, 10'h010);
		sendBubble();
		sendBubble();
		checkValue(16'(branchTarget), 16'h2a5, "jmp target");
		// 0x3fe plus 0x3f lands on 0x03d
		sendInstr(opLdca, 10'h001, '0);
		sendInstr(opBane, 10'h0ff, 10'h3fe);
		sendBubble();
		sendBubble();
		checkValue(16'(branchTarget), 16'h03d, "wrapped target");
	endtask

	task automatic randomStreamTest();
		opcode_t keptOps[$];
		logic [31:0] r;
		logic [31:0] fields;
		int idx;
		int sent;
		for (int code = 0; code <= 'h28; code++) begin
			if (code <= 'h02 || (code >= 'h04 && code <= 'h15) || code >= 'h20)
				keptOps.push_back(opcode_t'(code[`OPCODE_W-1:0]));
		end
		sent = 0;
		while (sent < 200) begin
			r = $random(seed);
			fields = $random(seed);
			// roughly one slot in eight is a bubble
			if (r[2:0] == 3'd0) begin
				sendBubble();
			end else begin
				idx = int'(r[31:8]) % keptOps.size();
				sendInstr(keptOps[idx], fields[9:0], fields[19:10]);
				sent++;
			end
		end
		sendBubble();
		sendBubble();
	endtask

	// ------------------------------------------------------------
	// run control
	// ------------------------------------------------------------

	initial begin
		seed = 30;
		checkCount = 0;
		errorCount = 0;
		modelA = '0;
		modelB = '0;
		modelTaken = 1'b0;
		modelTarget = '0;
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		waitEdges(4, 1'b1);
		reset <= 1'b0;
		waitEdges(1, 1'b0);
		resetLoadTest();
		aluFormsTest();
		forwardingTest();
		branchTest();
		randomStreamTest();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog
	initial begin
		fork
			begin
				#(RUN_LIMIT);
				$display("timeout: run did not finish within its time limit");
			end
			@(abortRun);
		join_any
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- sources.f
+incdir+source
source/accCorePkg.sv
source/alu.sv
source/instrDecoder.sv
source/decodeStage.sv
source/executeStage.sv
source/accCore.sv
tests/accCoreTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
	--top-module accCoreTb -o accCoreSim --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/accCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
